// File: Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing
TOP      ?= decode_stage_tb
FILELIST ?= vlog.f

.PHONY: simulate clean

simulate:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic [rv32i_types_pkg::INSTR_W-1:0]    instr_i,
  output decode_ctrl_pkg::alu_op_t               alu_op_o,
  output decode_ctrl_pkg::w_sel_t                w_sel_o,
  output logic                                   wen_o,
  output logic                                   dren_o,
  output logic                                   dwen_o,
  output logic                                   branch_o,
  output logic                                   jump_o,
  output logic                                   illegal_o,
  output logic [rv32i_types_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [rv32i_types_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv32i_types_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [decode_ctrl_pkg::DATA_W-1:0]     imm_o
);

  import rv32i_types_pkg::*;
  import decode_ctrl_pkg::*;

  opcode_t           opcode;
  funct3_t           funct3;
  logic              known;
  logic [DATA_W-1:0] imm_i_fmt;
  logic [DATA_W-1:0] imm_s_fmt;
  logic [DATA_W-1:0] imm_b_fmt;
  logic [DATA_W-1:0] imm_u_fmt;
  logic [DATA_W-1:0] imm_j_fmt;

  // opcode class
  always_comb begin
    case (instr_i[6:0])
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD,
      STORE, IMMED, REGREG, SYSTEM, MISCMEM: opcode = opcode_t'(instr_i[6:0]);
      default:                               opcode = OP_NONE;
    endcase
  end

  assign known  = (opcode != OP_NONE);
  assign funct3 = funct3_t'(instr_i[14:12]);

  // register specifiers are zeroed for unknown words
  assign rd_o  = known ? instr_i[11:7]  : '0;
  assign rs1_o = known ? instr_i[19:15] : '0;
  assign rs2_o = known ? instr_i[24:20] : '0;

  // each immediate format takes its sign from bit 31
  assign imm_i_fmt = {{(DATA_W-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s_fmt = {{(DATA_W-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_fmt = {{(DATA_W-13){instr_i[31]}}, instr_i[31], instr_i[7],
                      instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_fmt = {instr_i[31:12], 12'b0};
  assign imm_j_fmt = {{(DATA_W-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                      instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    case (opcode)
      IMMED, LOAD, JALR: imm_o = imm_i_fmt;
      STORE:             imm_o = imm_s_fmt;
      BRANCH:            imm_o = imm_b_fmt;
      LUI, AUIPC:        imm_o = imm_u_fmt;
      JAL:               imm_o = imm_j_fmt;
      default:           imm_o = '0;
    endcase
  end

  // memory and control flow
  assign dren_o   = (opcode == LOAD);
  assign dwen_o   = (opcode == STORE);
  assign branch_o = (opcode == BRANCH);
  assign jump_o   = (opcode == JAL) || (opcode == JALR);

  // write-back source
  always_comb begin
    case (opcode)
      LOAD:                 w_sel_o = WSEL_LOAD;
      JAL, JALR:            w_sel_o = WSEL_LINK;
      LUI:                  w_sel_o = WSEL_LUI;
      IMMED, AUIPC, REGREG: w_sel_o = WSEL_ALU;
      SYSTEM:               w_sel_o = WSEL_SYSTEM;
      default:              w_sel_o = WSEL_LOAD;
    endcase
  end

  always_comb begin
    case (opcode)
      IMMED, LUI, AUIPC, REGREG,
      JAL, JALR, LOAD:            wen_o = 1'b1;
      default:                    wen_o = 1'b0;
    endcase
  end

  // ALU op defaults to add unless an integer op says otherwise
  // bit 30 picks sub for REGREG and arithmetic shift for both classes
  always_comb begin
    alu_op_o = ALU_ADD;
    if ((opcode == IMMED) || (opcode == REGREG)) begin
      case (funct3)
        ADDSUB: alu_op_o = ((opcode == REGREG) && instr_i[30]) ? ALU_SUB : ALU_ADD;
        SLL:    alu_op_o = ALU_SLL;
        SLT:    alu_op_o = ALU_SLT;
        SLTU:   alu_op_o = ALU_SLTU;
        XOR:    alu_op_o = ALU_XOR;
        SR:     alu_op_o = instr_i[30] ? ALU_SRA : ALU_SRL;
        OR:     alu_op_o = ALU_OR;
        AND:    alu_op_o = ALU_AND;
      endcase
    end
  end

  // funct7 bit 0 on REGREG belongs to the M extension
  assign illegal_o = (opcode == REGREG) ? instr_i[25] :
                     (!known && (instr_i[6:0] != 7'b0));

endmodule

`default_nettype wire

// File: hw/decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

  // instructions per fetch bundle
  localparam int LANES  = 2;

  // width of the sign-extended immediate
  localparam int DATA_W = 32;

  // operation handed to the execute ALU
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // write-back source select
  typedef enum logic [2:0] {
    WSEL_LOAD   = 3'd0,
    WSEL_LINK   = 3'd1,
    WSEL_LUI    = 3'd2,
    WSEL_ALU    = 3'd3,
    WSEL_SYSTEM = 3'd4
  } w_sel_t;

endpackage

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic                                   fetch_valid_i,
  input  logic [rv32i_types_pkg::INSTR_W-1:0]    fetch_bundle_i [decode_ctrl_pkg::LANES],
  output logic                                   issue_valid_o,
  output logic [decode_ctrl_pkg::LANES-1:0]      issue_mask_o,
  output logic                                   illegal_o,
  output decode_ctrl_pkg::alu_op_t               alu_op_o  [decode_ctrl_pkg::LANES],
  output decode_ctrl_pkg::w_sel_t                w_sel_o   [decode_ctrl_pkg::LANES],
  output logic                                   wen_o     [decode_ctrl_pkg::LANES],
  output logic                                   dren_o    [decode_ctrl_pkg::LANES],
  output logic                                   dwen_o    [decode_ctrl_pkg::LANES],
  output logic                                   branch_o  [decode_ctrl_pkg::LANES],
  output logic                                   jump_o    [decode_ctrl_pkg::LANES],
  output logic [rv32i_types_pkg::REG_ADDR_W-1:0] rd_o      [decode_ctrl_pkg::LANES],
  output logic [decode_ctrl_pkg::DATA_W-1:0]     imm_o     [decode_ctrl_pkg::LANES]
);

  import rv32i_types_pkg::*;
  import decode_ctrl_pkg::*;

  logic [INSTR_W-1:0]    lane_instr   [LANES];
  logic [LANES-1:0]      lane_valid;
  alu_op_t               lane_alu_op  [LANES];
  w_sel_t                lane_w_sel   [LANES];
  logic                  lane_wen     [LANES];
  logic                  lane_dren    [LANES];
  logic                  lane_dwen    [LANES];
  logic                  lane_branch  [LANES];
  logic                  lane_jump    [LANES];
  logic                  lane_illegal [LANES];
  logic [REG_ADDR_W-1:0] lane_rd      [LANES];
  logic [REG_ADDR_W-1:0] lane_rs1     [LANES];
  logic [REG_ADDR_W-1:0] lane_rs2     [LANES];
  logic [DATA_W-1:0]     lane_imm     [LANES];

  fetch_bundle u_fetch_bundle (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_bundle_i (fetch_bundle_i),
    .lane_instr_o   (lane_instr),
    .lane_valid_o   (lane_valid)
  );

  // one decoder per lane
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    control_unit u_control_unit (
      .instr_i   (lane_instr[g]),
      .alu_op_o  (lane_alu_op[g]),
      .w_sel_o   (lane_w_sel[g]),
      .wen_o     (lane_wen[g]),
      .dren_o    (lane_dren[g]),
      .dwen_o    (lane_dwen[g]),
      .branch_o  (lane_branch[g]),
      .jump_o    (lane_jump[g]),
      .illegal_o (lane_illegal[g]),
      .rd_o      (lane_rd[g]),
      .rs1_o     (lane_rs1[g]),
      .rs2_o     (lane_rs2[g]),
      .imm_o     (lane_imm[g])
    );
  end

  issue_register u_issue_register (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lane_valid_i  (lane_valid),
    .alu_op_i      (lane_alu_op),
    .w_sel_i       (lane_w_sel),
    .wen_i         (lane_wen),
    .dren_i        (lane_dren),
    .dwen_i        (lane_dwen),
    .branch_i      (lane_branch),
    .jump_i        (lane_jump),
    .illegal_i     (lane_illegal),
    .rd_i          (lane_rd),
    .rs1_i         (lane_rs1),
    .rs2_i         (lane_rs2),
    .imm_i         (lane_imm),
    .issue_valid_o (issue_valid_o),
    .issue_mask_o  (issue_mask_o),
    .illegal_o     (illegal_o),
    .alu_op_o      (alu_op_o),
    .w_sel_o       (w_sel_o),
    .wen_o         (wen_o),
    .dren_o        (dren_o),
    .dwen_o        (dwen_o),
    .branch_o      (branch_o),
    .jump_o        (jump_o),
    .rd_o          (rd_o),
    .imm_o         (imm_o)
  );

endmodule

`default_nettype wire

// File: hw/fetch_bundle.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_bundle (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                fetch_valid_i,
  input  logic [rv32i_types_pkg::INSTR_W-1:0] fetch_bundle_i [decode_ctrl_pkg::LANES],
  output logic [rv32i_types_pkg::INSTR_W-1:0] lane_instr_o   [decode_ctrl_pkg::LANES],
  output logic [decode_ctrl_pkg::LANES-1:0]   lane_valid_o
);

  import decode_ctrl_pkg::*;

  logic [LANES-1:0] valid_d;

  // every lane of a bundle shares the fetch strobe
  assign valid_d = {LANES{fetch_valid_i}};

  // lane valids follow the registered strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lane_valid_o <= '0;
    end else begin
      lane_valid_o <= valid_d;
    end
  end

  // instruction words only load on the strobe
  // an idle cycle leaves them untouched
  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      for (int l = 0; l < LANES; l++) begin
        lane_instr_o[l] <= fetch_bundle_i[l];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/issue_register.sv
`timescale 1ns/1ps
`default_nettype none

module issue_register (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic [decode_ctrl_pkg::LANES-1:0]      lane_valid_i,
  input  decode_ctrl_pkg::alu_op_t               alu_op_i  [decode_ctrl_pkg::LANES],
  input  decode_ctrl_pkg::w_sel_t                w_sel_i   [decode_ctrl_pkg::LANES],
  input  logic                                   wen_i     [decode_ctrl_pkg::LANES],
  input  logic                                   dren_i    [decode_ctrl_pkg::LANES],
  input  logic                                   dwen_i    [decode_ctrl_pkg::LANES],
  input  logic                                   branch_i  [decode_ctrl_pkg::LANES],
  input  logic                                   jump_i    [decode_ctrl_pkg::LANES],
  input  logic                                   illegal_i [decode_ctrl_pkg::LANES],
  input  logic [rv32i_types_pkg::REG_ADDR_W-1:0] rd_i      [decode_ctrl_pkg::LANES],
  input  logic [rv32i_types_pkg::REG_ADDR_W-1:0] rs1_i     [decode_ctrl_pkg::LANES],
  input  logic [rv32i_types_pkg::REG_ADDR_W-1:0] rs2_i     [decode_ctrl_pkg::LANES],
  input  logic [decode_ctrl_pkg::DATA_W-1:0]     imm_i     [decode_ctrl_pkg::LANES],
  output logic                                   issue_valid_o,
  output logic [decode_ctrl_pkg::LANES-1:0]      issue_mask_o,
  output logic                                   illegal_o,
  output decode_ctrl_pkg::alu_op_t               alu_op_o  [decode_ctrl_pkg::LANES],
  output decode_ctrl_pkg::w_sel_t                w_sel_o   [decode_ctrl_pkg::LANES],
  output logic                                   wen_o     [decode_ctrl_pkg::LANES],
  output logic                                   dren_o    [decode_ctrl_pkg::LANES],
  output logic                                   dwen_o    [decode_ctrl_pkg::LANES],
  output logic                                   branch_o  [decode_ctrl_pkg::LANES],
  output logic                                   jump_o    [decode_ctrl_pkg::LANES],
  output logic [rv32i_types_pkg::REG_ADDR_W-1:0] rd_o      [decode_ctrl_pkg::LANES],
  output logic [decode_ctrl_pkg::DATA_W-1:0]     imm_o     [decode_ctrl_pkg::LANES]
);

  import decode_ctrl_pkg::*;

  logic [LANES-1:0] mask_d;
  logic             illegal_d;

  // a lane issues if valid, legal and free of a RAW on any lower lane
  // x0 as destination never blocks
  always_comb begin
    mask_d    = '0;
    illegal_d = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      mask_d[l] = lane_valid_i[l] && !illegal_i[l];
      illegal_d = illegal_d || (lane_valid_i[l] && illegal_i[l]);
      for (int e = 0; e < l; e++) begin
        if (wen_i[e] && (rd_i[e] != '0) &&
            ((rs1_i[l] == rd_i[e]) || (rs2_i[l] == rd_i[e]))) begin
          mask_d[l] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issue_valid_o <= 1'b0;
      issue_mask_o  <= '0;
      illegal_o     <= 1'b0;
    end else begin
      issue_valid_o <= |lane_valid_i;
      issue_mask_o  <= mask_d;
      illegal_o     <= illegal_d;
    end
  end

  // per-lane control words
  always_ff @(posedge clk_i) begin
    alu_op_o <= alu_op_i;
    w_sel_o  <= w_sel_i;
    wen_o    <= wen_i;
    dren_o   <= dren_i;
    dwen_o   <= dwen_i;
    branch_o <= branch_i;
    jump_o   <= jump_i;
    rd_o     <= rd_i;
    imm_o    <= imm_i;
  end

endmodule

`default_nettype wire

// File: hw/rv32i_types_pkg.sv
`default_nettype none

package rv32i_types_pkg;

  // base ISA widths
  localparam int INSTR_W    = 32;
  localparam int REG_ADDR_W = 5;

  // major opcode classes taken from bits [6:0] of the word
  // OP_NONE marks a word the decoder does not recognise
  typedef enum logic [6:0] {
    OP_NONE = 7'b0000000,
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    SYSTEM  = 7'b1110011,
    MISCMEM = 7'b0001111
  } opcode_t;

  // funct3 of the integer ops
  // same codes serve the IMMED and REGREG classes
  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } funct3_t;

  // field positions inside the instruction word
  //   rd     [11:7]
  //   funct3 [14:12]
  //   rs1    [19:15]
  //   rs2    [24:20]
  //   funct7 [31:25]

endpackage

`default_nettype wire

// File: verif/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

  import rv32i_types_pkg::*;
  import decode_ctrl_pkg::*;

  localparam int NUM_VEC    = 20;
  // words per vector line, and per lane group inside it
  localparam int REC_W      = 23;
  localparam int LANE_W     = 9;
  localparam int TIMEOUT_NS = (NUM_VEC + 20) * 10;

  logic                  clk_i;
  logic                  rst_i;
  logic                  fetch_valid_i;
  logic [INSTR_W-1:0]    fetch_bundle_i [LANES];
  logic                  issue_valid_o;
  logic [LANES-1:0]      issue_mask_o;
  logic                  illegal_o;
  alu_op_t               alu_op_o [LANES];
  w_sel_t                w_sel_o  [LANES];
  logic                  wen_o    [LANES];
  logic                  dren_o   [LANES];
  logic                  dwen_o   [LANES];
  logic                  branch_o [LANES];
  logic                  jump_o   [LANES];
  logic [REG_ADDR_W-1:0] rd_o     [LANES];
  logic [DATA_W-1:0]     imm_o    [LANES];

  logic [31:0] vec_mem [NUM_VEC*REC_W];

  decode_stage u_decode_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_bundle_i (fetch_bundle_i),
    .issue_valid_o  (issue_valid_o),
    .issue_mask_o   (issue_mask_o),
    .illegal_o      (illegal_o),
    .alu_op_o       (alu_op_o),
    .w_sel_o        (w_sel_o),
    .wen_o          (wen_o),
    .dren_o         (dren_o),
    .dwen_o         (dwen_o),
    .branch_o       (branch_o),
    .jump_o         (jump_o),
    .rd_o           (rd_o),
    .imm_o          (imm_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] field(input int v, input int f);
    return vec_mem[v*REC_W + f];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "decode output mismatch");
    end
  endtask

  task automatic drive_vector(input int v);
    logic [31:0] w;
    w = field(v, 0);
    fetch_valid_i     <= w[0];
    fetch_bundle_i[0] <= field(v, 1);
    fetch_bundle_i[1] <= field(v, 2);
  endtask

  // v below zero means no bundle is expected at the outputs
  task automatic compare_outputs(input int v);
    logic [31:0] valid_exp;
    int          b;
    valid_exp = (v < 0) ? 32'd0 : field(v, 0);
    check_value("issue_valid_o", {31'b0, issue_valid_o}, valid_exp);
    check_value("issue_mask_o", {30'b0, issue_mask_o}, (v < 0) ? 32'd0 : field(v, 3));
    check_value("illegal_o", {31'b0, illegal_o}, (v < 0) ? 32'd0 : field(v, 4));
    if (valid_exp[0]) begin
      for (int l = 0; l < LANES; l++) begin
        b = 5 + l*LANE_W;
        check_value($sformatf("alu_op_o[%0d]", l), 32'(alu_op_o[l]), field(v, b));
        check_value($sformatf("w_sel_o[%0d]", l), 32'(w_sel_o[l]), field(v, b+1));
        check_value($sformatf("wen_o[%0d]", l), {31'b0, wen_o[l]}, field(v, b+2));
        check_value($sformatf("dren_o[%0d]", l), {31'b0, dren_o[l]}, field(v, b+3));
        check_value($sformatf("dwen_o[%0d]", l), {31'b0, dwen_o[l]}, field(v, b+4));
        check_value($sformatf("branch_o[%0d]", l), {31'b0, branch_o[l]}, field(v, b+5));
        check_value($sformatf("jump_o[%0d]", l), {31'b0, jump_o[l]}, field(v, b+6));
        check_value($sformatf("rd_o[%0d]", l), {27'b0, rd_o[l]}, field(v, b+7));
        check_value($sformatf("imm_o[%0d]", l), imm_o[l], field(v, b+8));
      end
    end
  endtask

  initial begin
    int pipe [3];
    clk_i             = 1'b0;
    rst_i             = 1'b1;
    fetch_valid_i     = 1'b0;
    fetch_bundle_i[0] = '0;
    fetch_bundle_i[1] = '0;
    pipe[0]           = -1;
    pipe[1]           = -1;
    pipe[2]           = -1;
    $readmemh("verif/decode_vectors.mem", vec_mem);

    // reset held for four edges
    // outputs stay low throughout
    for (int r = 0; r < 4; r++) begin
      @(posedge clk_i);
      if (r == 3) begin
        rst_i <= 1'b0;
      end
      @(negedge clk_i);
      compare_outputs(-1);
    end

    // index delay line
    // a bundle shows up two edges after it is driven
    for (int j = 0; j < NUM_VEC + 2; j++) begin
      @(posedge clk_i);
      pipe[2] = pipe[1];
      pipe[1] = pipe[0];
      if (j < NUM_VEC) begin
        drive_vector(j);
        pipe[0] = j;
      end else begin
        fetch_valid_i <= 1'b0;
        pipe[0] = -1;
      end
      @(negedge clk_i);
      compare_outputs(pipe[2]);
    end

    $display(">>> PASS");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the vector run did not finish in time");
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: verif/decode_vectors.mem
// valid instr0 instr1 mask illegal, then per lane: alu_op w_sel wen dren dwen branch jump rd imm
// lane 0 group first, lane 1 group second; valid 0 marks a gap cycle
1 00500093 00700113 3 0 0 3 1 0 0 0 0 01 00000005 0 3 1 0 0 0 0 02 00000007
1 002081B3 40628233 3 0 0 3 1 0 0 0 0 03 00000000 1 3 1 0 0 0 0 04 00000000
1 01000293 00028333 1 0 0 3 1 0 0 0 0 05 00000010 0 3 1 0 0 0 0 06 00000000
1 00000013 000003B3 3 0 0 3 1 0 0 0 0 00 00000000 0 3 1 0 0 0 0 07 00000000
1 FE84AE23 008E2503 3 0 0 0 0 0 1 0 0 1C FFFFFFFC 0 0 1 1 0 0 0 0A 00000008
1 FE208CE3 FF1FF0EF 3 0 0 0 0 0 0 1 0 19 FFFFFFF8 0 1 1 0 0 0 1 01 FFFFFFF0
1 800015B7 FFFFF617 3 0 0 2 1 0 0 0 0 0B 80001000 0 3 1 0 0 0 0 0C FFFFF000
1 FFE280E7 00000073 3 0 0 1 1 0 0 0 1 01 FFFFFFFE 0 4 0 0 0 0 0 00 00000000
1 40375693 011817B3 3 0 4 3 1 0 0 0 0 0D 00000403 2 3 1 0 0 0 0 0F 00000000
1 0019D913 016ACA33 3 0 3 3 1 0 0 0 0 12 00000001 7 3 1 0 0 0 0 14 00000000
1 419C5BB3 FFFDAD13 3 0 4 3 1 0 0 0 0 17 00000000 8 3 1 0 0 0 0 1A FFFFFFFF
1 01FF3EB3 0FFEFF13 1 0 9 3 1 0 0 0 0 1D 00000000 5 3 1 0 0 0 0 1E 000000FF
1 0020E493 00912023 1 0 6 3 1 0 0 0 0 09 00000002 0 0 0 0 1 0 0 00 00000000
0 00000000 00000000 0 0 0 0 0 0 0 0 0 00 00000000 0 0 0 0 0 0 0 00 00000000
1 0000007F 00500093 2 1 0 0 0 0 0 0 0 00 00000000 0 3 1 0 0 0 0 01 00000005
1 00000013 022081B3 1 1 0 3 1 0 0 0 0 00 00000000 0 3 1 0 0 0 0 03 00000000
0 00000000 00000000 0 0 0 0 0 0 0 0 0 00 00000000 0 0 0 0 0 0 0 00 00000000
1 0FF0000F 00000000 3 0 0 0 0 0 0 0 0 00 00000000 0 0 0 0 0 0 0 00 00000000
1 FFF30283 00029863 1 0 0 0 1 1 0 0 0 05 FFFFFFFF 0 0 0 0 0 1 0 10 00000010
1 000010B7 00108113 1 0 0 2 1 0 0 0 0 01 00001000 0 3 1 0 0 0 0 02 00000001

// File: vlog.f
hw/rv32i_types_pkg.sv
hw/decode_ctrl_pkg.sv
hw/fetch_bundle.sv
hw/control_unit.sv
hw/issue_register.sv
hw/decode_stage.sv
verif/decode_stage_tb.sv
